// File: Makefile
# Verilator build and run of the L1 tag side testbench

TOP = l1_tag_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// File: project.f
+incdir+verilog
verilog/l1_tag_pkg.sv
verilog/tag_request_decode.sv
verilog/tag_mem.sv
verilog/hit_resolve.sv
verilog/l1_tag_top.sv
tb/l1_tag_chk.sv
tb/l1_tag_tb.sv

// File: tb/l1_tag_chk.sv
// Assertions for the L1 tag side
// Bound into the top level, where the tag memory's lookup result and the
// Wishbone handshake are both visible.

`timescale 1ns/1ns

module l1_tag_chk
	import l1_tag_pkg::*;
	(
	input logic        clk,
	input logic        reset_i,
	input logic        wb_cyc_i,
	input logic        wb_stb_i,
	input logic        wb_ack_i,
	input tag_lookup_t lookup_i
	);

	// number of assertion failures so far
	int failures = 0;

	// two ways with the same valid tag in one set would mean a broken fill
	one_hit_way: assert property (@(posedge clk) disable iff (reset_i)
		lookup_i.valid |-> $onehot0(lookup_i.hit_vec))
	else
	begin
		$error("more than one way hit in set %0d", lookup_i.set_idx);
		failures++;
	end

	ack_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
		wb_ack_i |=> !wb_ack_i)
	else
	begin
		$error("ack stayed high for more than one cycle");
		failures++;
	end

	ack_in_bus_cycle: assert property (@(posedge clk) disable iff (reset_i)
		wb_ack_i |-> (wb_cyc_i && wb_stb_i))
	else
	begin
		$error("ack raised without cyc and stb");
		failures++;
	end

endmodule

bind l1_tag_top l1_tag_chk chk0
(
	.clk      (clk),
	.reset_i  (reset_i),
	.wb_cyc_i (wb_cyc_i),
	.wb_stb_i (wb_stb_i),
	.wb_ack_i (wb_ack_o),
	.lookup_i (lookup)
);

// File: tb/l1_tag_tb.sv
// Testbench for the L1 cache tag side
// Runs a directed table of fills, invalidates and lookups, then a seeded
// random section that is checked against a model of tags and pseudo-LRU bits.

`timescale 1ns/1ns
`include "l1_cache_cfg.svh"

module l1_tag_tb
	import l1_tag_pkg::*;
	();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_ROWS = 22;
	localparam int NUM_RANDOM = 40;
	// falling edges from the drive to the ack, the first one comes before acceptance
	localparam int ACK_LATENCY = 4;
	localparam int ACK_LIMIT = 10;
	localparam int TAG_W = `L1_TAG_WIDTH;
	localparam int SET_W = `L1_SET_INDEX_WIDTH;

	typedef logic [TAG_W - 1:0] tag_bits_t;
	typedef logic [SET_W - 1:0] set_bits_t;

	// one directed step with its expected response
	typedef struct packed
	{
		tag_cmd_t    op;
		logic [31:0] adr;
		way_t        way;
		logic        hit;
		way_t        hit_way;
		way_t        victim;
	} row_t;

	localparam tag_bits_t TAG_A = 'h0a5a5;
	localparam tag_bits_t TAG_B = 'h1b00b;
	localparam tag_bits_t TAG_C = 'h0c0de;
	localparam tag_bits_t TAG_D = 'h1d00d;
	localparam tag_bits_t TAG_X = 'h0f00f;

	logic        clk;
	logic        reset_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [31:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic        wb_ack_o;
	logic [31:0] wb_dat_o;

	row_t rows [$];

	// reference model, indexed by set and way
	logic       model_valid [`L1_NUM_SETS][`L1_NUM_WAYS];
	tag_bits_t  model_tag [`L1_NUM_SETS][`L1_NUM_WAYS];
	logic [2:0] model_tree [`L1_NUM_SETS];

	int errors = 0;
	int tests = 0;
	int seed = 62;

	l1_tag_top dut0
	(
		.clk      (clk),
		.reset_i  (reset_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_ack_o (wb_ack_o),
		.wb_dat_o (wb_dat_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// each transaction needs about five cycles, ten per step leaves margin
	initial
	begin
		#((NUM_ROWS + NUM_RANDOM) * 10 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("** Error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
			errors++;
		end
	endtask

	function automatic logic [31:0] line_addr(input tag_bits_t tag, input set_bits_t set_idx);
		return {tag, set_idx, {`L1_LINE_OFFSET_WIDTH{1'b0}}};
	endfunction

	// after a use of way w the tree points to the other pair and the other way
	task automatic point_away(input int set_idx, input way_t w);
		if (!w[1])
		begin
			model_tree[set_idx][0] = 1'b1;
			model_tree[set_idx][1] = (w == 2'd0);
		end
		else
		begin
			model_tree[set_idx][0] = 1'b0;
			model_tree[set_idx][2] = (w == 2'd2);
		end
	endtask

	task automatic model_access(input tag_cmd_t op, input logic [31:0] adr, input way_t way,
		output logic hit, output way_t hit_way, output way_t victim);
		int set_idx;
		tag_bits_t tag;
		set_idx = int'(adr[`L1_LINE_OFFSET_WIDTH +: SET_W]);
		tag = adr[31 -: TAG_W];
		hit = 1'b0;
		hit_way = 2'd0;
		if (model_tree[set_idx][0])
			victim = model_tree[set_idx][2] ? 2'd3 : 2'd2;
		else
			victim = model_tree[set_idx][1] ? 2'd1 : 2'd0;
		if (op == CMD_LOOKUP)
		begin
			for (int w = `L1_NUM_WAYS - 1; w >= 0; w--)
				if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag)
				begin
					hit = 1'b1;
					hit_way = way_t'(w);
				end
			if (hit)
				point_away(set_idx, hit_way);
		end
		else
		begin
			model_valid[set_idx][way] = (op == CMD_FILL);
			if (op == CMD_FILL)
			begin
				model_tag[set_idx][way] = tag;
				point_away(set_idx, way);
			end
			// fills and invalidates return an all-zero word
			victim = 2'd0;
		end
	endtask

	task automatic bus_transfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
		output logic [31:0] rdata, output logic acked);
		int cycles;
		@(posedge clk);
		#2;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr;
		wb_dat_i = dat;
		cycles = 0;
		acked = 1'b0;
		rdata = '0;
		// outputs are sampled at the falling edge, away from register updates
		while (!acked && cycles < ACK_LIMIT)
		begin
			@(negedge clk);
			cycles++;
			if (wb_ack_o)
			begin
				acked = 1'b1;
				rdata = wb_dat_o;
			end
		end
		if (!acked)
		begin
			$display("no acknowledge within %0d cycles for address %h", ACK_LIMIT, adr);
			errors++;
		end
		else
			check_value("wb_ack_o latency", ACK_LATENCY, cycles);
		@(posedge clk);
		#2;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		@(negedge clk);
		check_value("wb_ack_o", 32'd0, 32'(wb_ack_o));
	endtask

	task automatic run_test(input string label, input int num, input tag_cmd_t op,
		input logic [31:0] adr, input way_t way, input logic exp_hit, input way_t exp_hit_way,
		input way_t exp_victim);
		logic [31:0] rdata;
		logic acked;
		int errors_before;
		errors_before = errors;
		bus_transfer(op != CMD_LOOKUP, adr, {29'd0, way, op == CMD_FILL}, rdata, acked);
		if (acked && op == CMD_LOOKUP)
		begin
			check_value("wb_dat_o hit", 32'(exp_hit), 32'(rdata[4]));
			if (exp_hit)
				check_value("wb_dat_o hit way", 32'(exp_hit_way), 32'(rdata[3:2]));
			check_value("wb_dat_o victim way", 32'(exp_victim), 32'(rdata[1:0]));
			check_value("wb_dat_o upper bits", 32'd0, 32'(rdata[31:5]));
		end
		else if (acked)
			check_value("wb_dat_o", 32'd0, rdata);
		tests++;
		$display("%s %0d: %s set %0d tag %h way %0d %s", label, num, op.name(),
			adr[`L1_LINE_OFFSET_WIDTH +: SET_W], adr[31 -: TAG_W], way,
			(errors == errors_before) ? "ok" : "mismatch");
	endtask

	task automatic add_row(input tag_cmd_t op, input logic [31:0] adr, input way_t way,
		input logic hit, input way_t hit_way, input way_t victim);
		rows.push_back(row_t'{op, adr, way, hit, hit_way, victim});
	endtask

	// victims worked out by hand from the tree rule, set 3 unless noted
	task automatic build_table();
		add_row(CMD_LOOKUP, line_addr('h12345, 5'd3), 2'd0, 1'b0, 2'd0, 2'd0);
		add_row(CMD_LOOKUP, line_addr('h00000, 5'd17), 2'd0, 1'b0, 2'd0, 2'd0);
		add_row(CMD_FILL, line_addr(TAG_A, 5'd3), 2'd0, 1'b0, 2'd0, 2'd0);
		add_row(CMD_FILL, line_addr(TAG_B, 5'd3), 2'd1, 1'b0, 2'd0, 2'd0);
		add_row(CMD_FILL, line_addr(TAG_C, 5'd3), 2'd2, 1'b0, 2'd0, 2'd0);
		add_row(CMD_FILL, line_addr(TAG_D, 5'd3), 2'd3, 1'b0, 2'd0, 2'd0);
		add_row(CMD_LOOKUP, line_addr(TAG_A, 5'd3), 2'd0, 1'b1, 2'd0, 2'd0);
		add_row(CMD_LOOKUP, line_addr(TAG_B, 5'd3), 2'd0, 1'b1, 2'd1, 2'd2);
		add_row(CMD_LOOKUP, line_addr(TAG_C, 5'd3), 2'd0, 1'b1, 2'd2, 2'd2);
		add_row(CMD_LOOKUP, line_addr(TAG_D, 5'd3), 2'd0, 1'b1, 2'd3, 2'd0);
		add_row(CMD_LOOKUP, line_addr(TAG_X, 5'd3), 2'd0, 1'b0, 2'd0, 2'd0);
		add_row(CMD_LOOKUP, line_addr(TAG_B, 5'd3), 2'd0, 1'b1, 2'd1, 2'd0);
		add_row(CMD_INVALIDATE, line_addr(TAG_C, 5'd3), 2'd2, 1'b0, 2'd0, 2'd0);
		add_row(CMD_LOOKUP, line_addr(TAG_C, 5'd3), 2'd0, 1'b0, 2'd0, 2'd2);
		add_row(CMD_LOOKUP, line_addr(TAG_A, 5'd3), 2'd0, 1'b1, 2'd0, 2'd2);
		add_row(CMD_LOOKUP, line_addr(TAG_D, 5'd3), 2'd0, 1'b1, 2'd3, 2'd2);
		add_row(CMD_LOOKUP, line_addr(TAG_C, 5'd3), 2'd0, 1'b0, 2'd0, 2'd1);
		add_row(CMD_FILL, line_addr(TAG_C, 5'd3), 2'd2, 1'b0, 2'd0, 2'd0);
		add_row(CMD_LOOKUP, line_addr(TAG_C, 5'd3), 2'd0, 1'b1, 2'd2, 2'd1);
		add_row(CMD_LOOKUP, line_addr(TAG_B, 5'd3), 2'd0, 1'b1, 2'd1, 2'd1);
		add_row(CMD_LOOKUP, line_addr(TAG_X, 5'd3), 2'd0, 1'b0, 2'd0, 2'd3);
		// a neighbouring set has seen none of this
		add_row(CMD_LOOKUP, line_addr(TAG_A, 5'd4), 2'd0, 1'b0, 2'd0, 2'd0);
	endtask

	task automatic random_section();
		logic [31:0] rnd;
		tag_cmd_t op;
		set_bits_t set_idx;
		tag_bits_t tag;
		way_t way;
		logic [31:0] adr;
		logic exp_hit;
		way_t exp_hit_way;
		way_t exp_victim;
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			rnd = $random(seed);
			case (rnd[1:0])
				2'd1: op = CMD_FILL;
				2'd2: op = CMD_INVALIDATE;
				default: op = CMD_LOOKUP;
			endcase
			// four sets and eight tags keep the hit rate up
			set_idx = set_bits_t'(2 + int'(rnd[5:4]));
			tag = tag_bits_t'(32'h100 + 32'(rnd[10:8]));
			way = rnd[13:12];
			// a tag already in the set is refilled in place, never duplicated
			for (int w = 0; w < `L1_NUM_WAYS; w++)
				if (op == CMD_FILL && model_valid[set_idx][w] && model_tag[set_idx][w] == tag)
					way = way_t'(w);
			adr = line_addr(tag, set_idx);
			model_access(op, adr, way, exp_hit, exp_hit_way, exp_victim);
			run_test("random", i, op, adr, way, exp_hit, exp_hit_way, exp_victim);
		end
	endtask

	initial
	begin
		logic hit;
		way_t hit_way;
		way_t victim;
		reset_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		for (int s = 0; s < `L1_NUM_SETS; s++)
		begin
			model_tree[s] = 3'b000;
			for (int w = 0; w < `L1_NUM_WAYS; w++)
				model_valid[s][w] = 1'b0;
		end
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset_i = 1'b0;
		// the model follows the table too, so the random section starts in step
		foreach (rows[i])
		begin
			model_access(rows[i].op, rows[i].adr, rows[i].way, hit, hit_way, victim);
			run_test("table", i, rows[i].op, rows[i].adr, rows[i].way, rows[i].hit,
				rows[i].hit_way, rows[i].victim);
		end
		random_section();
		if (dut0.chk0.failures != 0)
		begin
			$display("%0d assertion failures in the bound checker", dut0.chk0.failures);
			errors++;
		end
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: verilog/hit_resolve.sv
// Result stage of the L1 tag side
// Encodes the hit way, keeps three tree pseudo-LRU bits per set for the
// victim choice, and returns the response word with a one-cycle ack.

`timescale 1ns/1ns
`include "l1_cache_cfg.svh"

module hit_resolve
	import l1_tag_pkg::*;
	(
	input  logic        clk,
	input  logic        reset_i,
	input  tag_lookup_t lookup_i,
	output logic        wb_ack_o,
	output logic [31:0] wb_dat_o
	);

	// bit 0 picks the pair, bit 1 works inside ways 0/1, bit 2 inside ways 2/3
	logic [2:0] plru_bits [`L1_NUM_SETS];

	logic       is_lookup;
	logic       hit_any;
	way_t       hit_way;
	way_t       victim_way;
	logic [2:0] tree;
	logic       touch;
	way_t       touch_way;
	logic [2:0] tree_next;
	tag_resp_t  resp_d;
	tag_resp_t  resp_q;
	logic       ack_q;

	assign is_lookup = lookup_i.valid && (lookup_i.cmd == CMD_LOOKUP);
	assign hit_any = |lookup_i.hit_vec;
	assign tree = plru_bits[lookup_i.set_idx];

	// lowest hitting way wins
	always_comb
	begin
		hit_way = '0;
		for (int w = `L1_NUM_WAYS - 1; w >= 0; w--)
			if (lookup_i.hit_vec[w])
				hit_way = way_t'(w);
	end

	// victim is taken from the tree as it stands before this access
	assign victim_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

	// hits and fills make the tree point away from the way just used
	assign touch = (is_lookup && hit_any) ||
		(lookup_i.valid && (lookup_i.cmd == CMD_FILL));
	assign touch_way = is_lookup ? hit_way : lookup_i.way;

	always_comb
	begin
		tree_next = tree;
		tree_next[0] = ~touch_way[1];
		if (touch_way[1])
			tree_next[2] = ~touch_way[0];
		else
			tree_next[1] = ~touch_way[0];
	end

	assign resp_d = is_lookup ? '{hit: hit_any, hit_way: hit_way, victim_way: victim_way} : '0;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int s = 0; s < `L1_NUM_SETS; s++)
				plru_bits[s] <= 3'b000;
			ack_q <= 1'b0;
		end
		else
		begin
			if (touch)
				plru_bits[lookup_i.set_idx] <= tree_next;
			ack_q <= lookup_i.valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (lookup_i.valid)
			resp_q <= resp_d;
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = 32'(resp_q);

endmodule

// File: verilog/l1_cache_cfg.svh
// L1 cache geometry
// Sizes of the set index, line offset and tag fields of a 32-bit byte address,
// and the array sizes of the tag side.

`ifndef L1_CACHE_CFG_SVH
`define L1_CACHE_CFG_SVH

// number of sets in each way
`define L1_NUM_SETS 32

// must stay equal to log2 of the set count
`define L1_SET_INDEX_WIDTH 5

// 64-byte lines
`define L1_LINE_OFFSET_WIDTH 6

// everything above the set index is kept as the tag
`define L1_TAG_WIDTH (32 - `L1_LINE_OFFSET_WIDTH - `L1_SET_INDEX_WIDTH)

// the pseudo-LRU tree in the result stage is built for exactly four ways
`define L1_NUM_WAYS 4

`endif

// File: verilog/l1_tag_pkg.sv
// L1 tag side types
// Command encoding and the packed structs that travel from the bus decoder
// through the tag memory to the result stage.

`include "l1_cache_cfg.svh"

package l1_tag_pkg;

	// index of one of the four ways
	typedef logic [1:0] way_t;

	typedef enum logic [1:0]
	{
		CMD_LOOKUP     = 2'd0,
		CMD_FILL       = 2'd1,
		CMD_INVALIDATE = 2'd2
	} tag_cmd_t;

	// request as registered by the bus decoder
	typedef struct packed
	{
		logic                             valid;
		tag_cmd_t                         cmd;
		logic [`L1_SET_INDEX_WIDTH - 1:0] set_idx;
		logic [`L1_TAG_WIDTH - 1:0]       tag;
		way_t                             way;
	} tag_req_t;

	// request after the tag read, with one compare result per way
	typedef struct packed
	{
		logic                             valid;
		tag_cmd_t                         cmd;
		logic [`L1_SET_INDEX_WIDTH - 1:0] set_idx;
		logic [`L1_NUM_WAYS - 1:0]        hit_vec;
		way_t                             way;
	} tag_lookup_t;

	// zero-extended into the bus read data, hit sits in bit 4
	typedef struct packed
	{
		logic hit;
		way_t hit_way;
		way_t victim_way;
	} tag_resp_t;

endpackage

// File: verilog/l1_tag_top.sv
// L1 cache tag side, top level
// Wishbone classic slave made of the request decoder, the four-way tag memory
// and the hit and pseudo-LRU result stage.

`timescale 1ns/1ns

module l1_tag_top
	import l1_tag_pkg::*;
	(
	input  logic        clk,
	input  logic        reset_i,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [31:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic        wb_ack_o,
	output logic [31:0] wb_dat_o
	);

	tag_req_t    req;
	tag_lookup_t lookup;

	tag_request_decode decode0
	(
		.clk      (clk),
		.reset_i  (reset_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_o),
		.req_o    (req)
	);

	tag_mem mem0
	(
		.clk      (clk),
		.reset_i  (reset_i),
		.req_i    (req),
		.lookup_o (lookup)
	);

	// ack goes out on the bus and back to the decoder to release busy
	hit_resolve resolve0
	(
		.clk      (clk),
		.reset_i  (reset_i),
		.lookup_i (lookup),
		.wb_ack_o (wb_ack_o),
		.wb_dat_o (wb_dat_o)
	);

endmodule

// File: verilog/tag_mem.sv
// Four-way tag memory of the L1 cache
// Holds a valid bit and a tag per line. The four ways are read in parallel for
// the request's set, and the registered tags are compared against the request
// tag one cycle later. Fills and invalidates write the way the master chose.

`timescale 1ns/1ns
`include "l1_cache_cfg.svh"

module tag_mem
	import l1_tag_pkg::*;
	(
	input  logic        clk,
	input  logic        reset_i,
	input  tag_req_t    req_i,
	output tag_lookup_t lookup_o
	);

	// tag storage, one array per way
	logic [`L1_TAG_WIDTH - 1:0] tag_array [`L1_NUM_WAYS][`L1_NUM_SETS];

	// valid bits kept as flat vectors so that reset can clear them in one go
	logic [`L1_NUM_SETS - 1:0] valid_bits [`L1_NUM_WAYS];

	// read side, registered at the same edge as the request
	logic [`L1_TAG_WIDTH - 1:0] tag_q [`L1_NUM_WAYS];
	logic [`L1_NUM_WAYS - 1:0]  valid_q;
	tag_req_t                   req_q;

	logic [`L1_NUM_WAYS - 1:0] way_sel;
	logic [`L1_NUM_WAYS - 1:0] hit_vec;
	logic                      fill_en;
	logic                      inval_en;

	assign fill_en = req_i.valid && (req_i.cmd == CMD_FILL);
	assign inval_en = req_i.valid && (req_i.cmd == CMD_INVALIDATE);

	// one-hot select of the way a fill or invalidate targets
	always_comb
	begin
		for (int w = 0; w < `L1_NUM_WAYS; w++)
			way_sel[w] = (req_i.way == way_t'(w));
	end

	// tag read and write, a read of the set being written returns the old tag
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < `L1_NUM_WAYS; w++)
		begin
			tag_q[w] <= tag_array[w][req_i.set_idx];
			if (fill_en && way_sel[w])
				tag_array[w][req_i.set_idx] <= req_i.tag;
		end
	end

	// valid bits and their registered read
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int w = 0; w < `L1_NUM_WAYS; w++)
				valid_bits[w] <= '0;
			valid_q <= '0;
		end
		else
		begin
			for (int w = 0; w < `L1_NUM_WAYS; w++)
			begin
				valid_q[w] <= valid_bits[w][req_i.set_idx];
				if (way_sel[w])
				begin
					if (fill_en)
						valid_bits[w][req_i.set_idx] <= 1'b1;
					else if (inval_en)
						valid_bits[w][req_i.set_idx] <= 1'b0;
				end
			end
		end
	end

	// request follows the read data through the stage
	always_ff @(posedge clk)
	begin
		if (reset_i)
			req_q.valid <= 1'b0;
		else
			req_q.valid <= req_i.valid;
	end

	always_ff @(posedge clk)
	begin
		req_q.cmd <= req_i.cmd;
		req_q.set_idx <= req_i.set_idx;
		req_q.tag <= req_i.tag;
		req_q.way <= req_i.way;
	end

	// a way hits only if its line is valid and the stored tag matches
	always_comb
	begin
		for (int w = 0; w < `L1_NUM_WAYS; w++)
			hit_vec[w] = valid_q[w] && (tag_q[w] == req_q.tag);
	end

	always_comb
	begin
		lookup_o.valid = req_q.valid;
		lookup_o.cmd = req_q.cmd;
		lookup_o.set_idx = req_q.set_idx;
		lookup_o.hit_vec = hit_vec;
		lookup_o.way = req_q.way;
	end

endmodule

// File: verilog/tag_request_decode.sv
// Wishbone classic slave front end of the tag side
// Accepts one bus cycle at a time, splits the address into tag and set index
// and turns the cycle into a typed request. Busy holds until the ack returns.

`timescale 1ns/1ns
`include "l1_cache_cfg.svh"

module tag_request_decode
	import l1_tag_pkg::*;
	(
	input  logic        clk,
	input  logic        reset_i,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [31:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	input  logic        wb_ack_i,
	output tag_req_t    req_o
	);

	logic     busy;
	logic     accept;
	tag_cmd_t cmd_d;
	tag_req_t req_q;

	// the master holds stb until it sees ack, so busy keeps the held cycle
	// from being taken a second time
	assign accept = wb_cyc_i && wb_stb_i && !busy;

	// a read is a lookup, a write carries fill or invalidate in bit 0
	always_comb
	begin
		if (!wb_we_i)
			cmd_d = CMD_LOOKUP;
		else if (wb_dat_i[0])
			cmd_d = CMD_FILL;
		else
			cmd_d = CMD_INVALIDATE;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			busy <= 1'b0;
			req_q.valid <= 1'b0;
		end
		else
		begin
			if (wb_ack_i)
				busy <= 1'b0;
			else if (accept)
				busy <= 1'b1;
			req_q.valid <= accept;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_q.cmd <= cmd_d;
			req_q.set_idx <= wb_adr_i[`L1_LINE_OFFSET_WIDTH +: `L1_SET_INDEX_WIDTH];
			req_q.tag <= wb_adr_i[31 -: `L1_TAG_WIDTH];
			req_q.way <= wb_dat_i[2:1];
		end
	end

	assign req_o = req_q;

endmodule
